//--- hw/ahb_pkg.sv
// AHB-Lite bus widths, transfer encodings and the address-phase struct
`default_nettype none

package ahb_pkg;

  ////////////////////
  // bus widths
  ////////////////////
  localparam int HADDR_W     = 32;
  localparam int HDATA_W     = 32;
  localparam int HDATA_BYTES = HDATA_W / 8;
  // byte offset bits within one data word
  localparam int HDATA_OFS_W = $clog2(HDATA_BYTES);

  localparam int HTRANS_W    = 2;
  localparam int HSIZE_W     = 3;
  localparam int HBURST_W    = 3;

  // slave never signals an error
  localparam logic HRESP_OKAY = 1'b0;

  ////////////////////
  // transfer encodings
  ////////////////////
  typedef enum logic [HTRANS_W-1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } ahb_htrans_e;

  // only sizes up to the 32 bit bus width
  typedef enum logic [HSIZE_W-1:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HWORD = 3'b001,
    HSIZE_WORD  = 3'b010
  } ahb_hsize_e;

  typedef enum logic [HBURST_W-1:0] {
    HBURST_SINGLE = 3'b000,
    HBURST_INCR   = 3'b001,
    HBURST_WRAP4  = 3'b010,
    HBURST_INCR4  = 3'b011,
    HBURST_WRAP8  = 3'b100,
    HBURST_INCR8  = 3'b101,
    HBURST_WRAP16 = 3'b110,
    HBURST_INCR16 = 3'b111
  } ahb_hburst_e;

  // one address phase as sampled from the bus
  typedef struct packed {
    logic [HADDR_W-1:0] haddr;
    ahb_htrans_e        htrans;
    ahb_hsize_e         hsize;
    ahb_hburst_e        hburst;
    logic               hwrite;
  } ahb_addr_phase_t;

endpackage : ahb_pkg

`default_nettype wire

//--- hw/sdram_port_pkg.sv
// write buffer line geometry, idle timeout, scheduler request structs and read states
`default_nettype none

package sdram_port_pkg;

  import ahb_pkg::*;

  ////////////////////
  // line geometry
  ////////////////////
  // four bus words per line
  localparam int WB_WORDS      = 4;
  localparam int WB_LINE_W     = WB_WORDS * HDATA_W;
  localparam int WB_LINE_BYTES = WB_LINE_W / 8;
  // word select inside a line
  localparam int WB_IDX_W      = $clog2(WB_WORDS);
  // byte offset bits of a line address
  localparam int WB_OFS_W      = $clog2(WB_LINE_BYTES);
  localparam int WB_TAG_W      = HADDR_W - WB_OFS_W;

  // idle cycles before a dirty active line is pushed out
  localparam int WB_TIMEOUT    = 64;
  localparam int WB_TIMER_W    = $clog2(WB_TIMEOUT + 1);

  ////////////////////
  // scheduler requests
  ////////////////////
  // full line write, addr is line aligned
  typedef struct packed {
    logic [HADDR_W-1:0]       addr;
    logic [WB_LINE_BYTES-1:0] be;
    logic [WB_LINE_W-1:0]     data;
  } wr_req_t;

  // single word read, addr is word aligned
  typedef struct packed {
    logic [HADDR_W-1:0] addr;
  } rd_req_t;

  // registered data-phase beat
  typedef struct packed {
    logic                   wr;
    logic                   rd;
    logic [WB_TAG_W-1:0]    tag;
    logic [WB_IDX_W-1:0]    idx;
    logic [HDATA_BYTES-1:0] be;
  } beat_t;

  // read beat sequencing
  typedef enum logic [1:0] {
    RD_IDLE = 2'b00,
    RD_HOLD = 2'b01,
    RD_REQ  = 2'b10,
    RD_DATA = 2'b11
  } rd_state_e;

endpackage : sdram_port_pkg

`default_nettype wire

//--- hw/ahb_beat_capture.sv
// AHB address-phase decode and register, byte enable generation, tag and index split
`timescale 1ns/1ps
`default_nettype none

module ahb_beat_capture
  import ahb_pkg::*;
  import sdram_port_pkg::*;
(
  input  logic            HCLK,
  input  logic            HRESETn,
  input  logic            HSEL_i,
  input  logic            HREADY_i,
  input  ahb_addr_phase_t addr_phase_i,
  input  logic            accept_i,
  output beat_t           beat_o,
  output rd_req_t         rd_addr_o
);

  logic                   xfer;
  logic                   wr_dec;
  logic                   rd_dec;
  logic [HDATA_BYTES-1:0] be_dec;

  logic                   wr_q;
  logic                   rd_q;
  logic [WB_TAG_W-1:0]    tag_q;
  logic [WB_IDX_W-1:0]    idx_q;
  logic [HDATA_BYTES-1:0] be_q;
  logic [HADDR_W-1:0]     rd_addr_q;

  // BUSY and IDLE carry no beat
  assign xfer   = HSEL_i & ((addr_phase_i.htrans == HTRANS_NONSEQ) |
                            (addr_phase_i.htrans == HTRANS_SEQ));
  assign wr_dec = xfer &  addr_phase_i.hwrite;
  assign rd_dec = xfer & ~addr_phase_i.hwrite;

  // byte lanes from size and low address bits
  always_comb
  begin
    case (addr_phase_i.hsize)
      HSIZE_BYTE:  be_dec = HDATA_BYTES'(1) << addr_phase_i.haddr[HDATA_OFS_W-1:0];
      HSIZE_HWORD: be_dec = HDATA_BYTES'(3) << {addr_phase_i.haddr[1], 1'b0};
      default:     be_dec = {HDATA_BYTES{1'b1}};
    endcase
  end

  ////////////////////
  // beat registers
  ////////////////////
  // a finished beat with no new address phase behind it is dropped
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      wr_q <= 1'b0;
      rd_q <= 1'b0;
    end
    else if (HREADY_i)
    begin
      wr_q <= wr_dec;
      rd_q <= rd_dec;
    end
    else if (accept_i)
    begin
      wr_q <= 1'b0;
      rd_q <= 1'b0;
    end
  end

  // address payload, only meaningful with a valid flag
  always_ff @(posedge HCLK)
  begin
    if (HREADY_i)
    begin
      tag_q     <= addr_phase_i.haddr[HADDR_W-1 -: WB_TAG_W];
      idx_q     <= addr_phase_i.haddr[WB_OFS_W-1 -: WB_IDX_W];
      be_q      <= be_dec;
      // reads always fetch the whole word
      rd_addr_q <= {addr_phase_i.haddr[HADDR_W-1:HDATA_OFS_W], {HDATA_OFS_W{1'b0}}};
    end
  end

  assign beat_o.wr      = wr_q;
  assign beat_o.rd      = rd_q;
  assign beat_o.tag     = tag_q;
  assign beat_o.idx     = idx_q;
  assign beat_o.be      = be_q;
  assign rd_addr_o.addr = rd_addr_q;

endmodule : ahb_beat_capture

`default_nettype wire

//--- hw/write_combine_buffer.sv
// ping-pong write-combining buffer with merge, swap, idle timeout and line write request
`timescale 1ns/1ps
`default_nettype none

module write_combine_buffer
  import ahb_pkg::*;
  import sdram_port_pkg::*;
(
  input  logic                HCLK,
  input  logic                HRESETn,
  input  beat_t               beat_i,
  input  logic [HDATA_W-1:0]  hwdata_i,
  input  logic                accept_i,
  input  logic [WB_TAG_W-1:0] rd_tag_i,
  input  logic                rd_tag_valid_i,
  output logic                wr_stall_o,
  output logic                rd_hold_o,
  output logic                wrreq_o,
  output wr_req_t             wr_o,
  input  logic                wrrdy_i
);

  // line storage
  logic [WB_LINE_W-1:0]     line_data  [2];
  logic [WB_TAG_W-1:0]      line_tag   [2];
  logic [WB_LINE_BYTES-1:0] line_be    [2];
  logic                     line_dirty [2];

  logic [WB_LINE_BYTES-1:0] be_nxt     [2];
  logic                     dirty_nxt  [2];
  logic                     line_clr   [2];
  logic                     line_mrg   [2];

  // ptr selects the active line, the other one drains
  logic                     ptr;
  logic                     act;
  logic                     oth;
  logic                     tgt;

  logic                     wr_accept;
  logic                     other_free;
  logic                     miss_swap;
  logic                     rdhit_swap;
  logic                     swap;
  logic                     merge;
  logic [WB_LINE_BYTES-1:0] merge_be;
  logic [WB_LINE_W-1:0]     wdata_line;

  logic [WB_TIMER_W-1:0]    timer;
  logic                     expired;
  logic                     restart;

  assign act = ptr;
  assign oth = ~ptr;

  ////////////////////
  // swap decision
  ////////////////////
  assign wr_accept  = wrreq_o & wrrdy_i;
  // other line empty now or drained at this edge
  assign other_free = ~line_dirty[oth] | wr_accept;

  // write to a different line than the dirty active one
  assign miss_swap  = beat_i.wr & line_dirty[act] & (line_tag[act] != beat_i.tag);
  // read of the active dirty line, push it out first
  assign rdhit_swap = rd_tag_valid_i & line_dirty[act] & (line_tag[act] == rd_tag_i);

  assign swap       = (miss_swap | rdhit_swap | expired) & other_free;

  // only the registered dirty flag stalls the bus
  assign wr_stall_o = miss_swap & line_dirty[oth];

  // read must wait for every dirty copy of its line
  assign rd_hold_o  = rd_tag_valid_i &
                      ((line_dirty[0] & (line_tag[0] == rd_tag_i)) |
                       (line_dirty[1] & (line_tag[1] == rd_tag_i)));

  ////////////////////
  // merge
  ////////////////////
  assign merge      = beat_i.wr & accept_i;
  // merge goes into the line that is active after this edge
  assign tgt        = swap ? oth : act;
  assign merge_be   = WB_LINE_BYTES'(beat_i.be) << {beat_i.idx, {HDATA_OFS_W{1'b0}}};
  assign wdata_line = {WB_WORDS{hwdata_i}};

  // per line clear on drain, then or in the new lanes
  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      line_clr[i]  = wr_accept & (oth == 1'(i));
      line_mrg[i]  = merge & (tgt == 1'(i));
      be_nxt[i]    = line_clr[i] ? {WB_LINE_BYTES{1'b0}} : line_be[i];
      dirty_nxt[i] = line_dirty[i] & ~line_clr[i];
      if (line_mrg[i])
      begin
        be_nxt[i]    = be_nxt[i] | merge_be;
        dirty_nxt[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (merge)
    begin
      line_tag[tgt] <= beat_i.tag;
      for (int b = 0; b < WB_LINE_BYTES; b++)
      begin
        if (merge_be[b])
          line_data[tgt][8*b +: 8] <= wdata_line[8*b +: 8];
      end
    end
  end

  // idle timer restarts on writes, swaps and a clean active line
  assign restart = ~line_dirty[act] | merge | swap;
  assign expired = (timer == WB_TIMER_W'(WB_TIMEOUT));

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      ptr   <= 1'b0;
      timer <= '0;
      for (int i = 0; i < 2; i++)
      begin
        line_be[i]    <= '0;
        line_dirty[i] <= 1'b0;
      end
    end
    else
    begin
      ptr <= ptr ^ swap;
      if (restart)
        timer <= '0;
      else if (!expired)
        timer <= timer + 1'b1;
      for (int i = 0; i < 2; i++)
      begin
        line_be[i]    <= be_nxt[i];
        line_dirty[i] <= dirty_nxt[i];
      end
    end
  end

  ////////////////////
  // line write request
  ////////////////////
  // inactive line is never written so the request holds still
  assign wrreq_o    = line_dirty[oth];
  assign wr_o.addr  = {line_tag[oth], {WB_OFS_W{1'b0}}};
  assign wr_o.be    = line_be[oth];
  assign wr_o.data  = line_data[oth];

endmodule : write_combine_buffer

`default_nettype wire

//--- hw/read_sequencer.sv
// read beat FSM, single-word read request, HRDATA register and HREADYOUT decode
`timescale 1ns/1ps
`default_nettype none

module read_sequencer
  import ahb_pkg::*;
  import sdram_port_pkg::*;
(
  input  logic                HCLK,
  input  logic                HRESETn,
  input  beat_t               beat_i,
  input  rd_req_t             rd_addr_i,
  input  logic                wr_stall_i,
  input  logic                rd_hold_i,
  output logic [WB_TAG_W-1:0] rd_tag_o,
  output logic                rd_tag_valid_o,
  output logic                rdreq_o,
  output rd_req_t             rd_o,
  input  logic                rdrdy_i,
  input  logic [HDATA_W-1:0]  rdq_i,
  input  logic                rdqvalid_i,
  output logic [HDATA_W-1:0]  hrdata_o,
  output logic                hreadyout_o
);

  rd_state_e          state;
  rd_state_e          state_nxt;
  // read data registered, completion cycle of the beat
  logic               rd_done_q;
  logic               rd_start;
  logic [HDATA_W-1:0] hrdata_q;

  // new read beat that is not yet served
  assign rd_start = beat_i.rd & ~rd_done_q;

  ////////////////////
  // read FSM
  ////////////////////
  always_comb
  begin
    state_nxt = state;
    case (state)
      RD_IDLE:
      begin
        // dirty line in the buffer goes out first
        if (rd_start)
          state_nxt = rd_hold_i ? RD_HOLD : RD_REQ;
      end
      RD_HOLD:
      begin
        if (!rd_hold_i)
          state_nxt = RD_REQ;
      end
      RD_REQ:
      begin
        if (rdrdy_i)
          state_nxt = RD_DATA;
      end
      RD_DATA:
      begin
        if (rdqvalid_i)
          state_nxt = RD_IDLE;
      end
      default: state_nxt = RD_IDLE;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state     <= RD_IDLE;
      rd_done_q <= 1'b0;
    end
    else
    begin
      state     <= state_nxt;
      // high for exactly one cycle per read beat
      rd_done_q <= (state == RD_DATA) & rdqvalid_i;
    end
  end

  // returned word
  always_ff @(posedge HCLK)
  begin
    if ((state == RD_DATA) && rdqvalid_i)
      hrdata_q <= rdq_i;
  end

  // tag lookup while the read may still meet a dirty line
  assign rd_tag_o       = rd_addr_i.addr[HADDR_W-1 -: WB_TAG_W];
  assign rd_tag_valid_o = rd_start & ((state == RD_IDLE) | (state == RD_HOLD));

  // request held by the state until accepted
  assign rdreq_o        = (state == RD_REQ);
  assign rd_o           = rd_addr_i;
  assign hrdata_o       = hrdata_q;

  // decoded from flops only
  // reads wait for their word, writes for a free line
  assign hreadyout_o    = beat_i.rd ? rd_done_q : ~wr_stall_i;

endmodule : read_sequencer

`default_nettype wire

//--- hw/sdram_ahb_port.sv
// AHB-Lite SDRAM data port top level with beat capture, write buffer and read sequencer
`timescale 1ns/1ps
`default_nettype none

module sdram_ahb_port
  import ahb_pkg::*;
  import sdram_port_pkg::*;
(
  input  logic                HCLK,
  input  logic                HRESETn,
  // AHB-Lite slave
  input  logic                HSEL_i,
  input  logic [HADDR_W-1:0]  HADDR_i,
  input  logic [HTRANS_W-1:0] HTRANS_i,
  input  logic [HSIZE_W-1:0]  HSIZE_i,
  input  logic [HBURST_W-1:0] HBURST_i,
  input  logic                HWRITE_i,
  input  logic [HDATA_W-1:0]  HWDATA_i,
  input  logic                HREADY_i,
  output logic [HDATA_W-1:0]  HRDATA_o,
  output logic                HREADYOUT_o,
  output logic                HRESP_o,
  // scheduler write port
  output logic                wrreq_o,
  output wr_req_t             wr_o,
  input  logic                wrrdy_i,
  // scheduler read port
  output logic                rdreq_o,
  output rd_req_t             rd_o,
  input  logic                rdrdy_i,
  input  logic [HDATA_W-1:0]  rdq_i,
  input  logic                rdqvalid_i
);

  ahb_addr_phase_t     addr_phase;
  beat_t               beat;
  rd_req_t             rd_addr;
  logic                accept;
  logic                wr_stall;
  logic                rd_hold;
  logic [WB_TAG_W-1:0] rd_tag;
  logic                rd_tag_valid;

  assign addr_phase.haddr  = HADDR_i;
  assign addr_phase.htrans = ahb_htrans_e'(HTRANS_i);
  assign addr_phase.hsize  = ahb_hsize_e'(HSIZE_i);
  assign addr_phase.hburst = ahb_hburst_e'(HBURST_i);
  assign addr_phase.hwrite = HWRITE_i;

  assign HRESP_o     = HRESP_OKAY;
  assign HREADYOUT_o = accept;

  ahb_beat_capture u_capture (
    .HCLK (HCLK), .HRESETn (HRESETn), .HSEL_i (HSEL_i), .HREADY_i (HREADY_i),
    .addr_phase_i (addr_phase), .accept_i (accept), .beat_o (beat), .rd_addr_o (rd_addr)
  );

  write_combine_buffer u_wbuf (
    .HCLK (HCLK), .HRESETn (HRESETn), .beat_i (beat), .hwdata_i (HWDATA_i),
    .accept_i (accept), .rd_tag_i (rd_tag), .rd_tag_valid_i (rd_tag_valid),
    .wr_stall_o (wr_stall), .rd_hold_o (rd_hold),
    .wrreq_o (wrreq_o), .wr_o (wr_o), .wrrdy_i (wrrdy_i)
  );

  read_sequencer u_rdseq (
    .HCLK (HCLK), .HRESETn (HRESETn), .beat_i (beat), .rd_addr_i (rd_addr),
    .wr_stall_i (wr_stall), .rd_hold_i (rd_hold), .rd_tag_o (rd_tag),
    .rd_tag_valid_o (rd_tag_valid), .rdreq_o (rdreq_o), .rd_o (rd_o), .rdrdy_i (rdrdy_i),
    .rdq_i (rdq_i), .rdqvalid_i (rdqvalid_i), .hrdata_o (HRDATA_o), .hreadyout_o (accept)
  );

endmodule : sdram_ahb_port

`default_nettype wire

//--- testbench/sdram_sched_model.sv
// SDRAM scheduler and byte memory model with random ready low runs and read latency
`timescale 1ns/1ps
`default_nettype none

module sdram_sched_model
  import ahb_pkg::*;
  import sdram_port_pkg::*;
(
  input  logic               HCLK,
  input  logic               HRESETn,
  input  logic               wrreq_i,
  input  wr_req_t            wr_i,
  output logic               wrrdy_o,
  input  logic               rdreq_i,
  input  rd_req_t            rd_i,
  output logic               rdrdy_o,
  output logic [HDATA_W-1:0] rdq_o,
  output logic               rdqvalid_o
);

  localparam logic [31:0] LFSR_SEED = 32'h2ca1_8f85;

  // 256 byte window
  logic [7:0] mem [256];
  logic [31:0] lfsr;
  int          wr_low;
  int          rd_low;
  int          rd_wait;
  logic        rd_busy;
  logic [7:0]  rd_ptr;
  // handshakes as seen just before the edge
  logic        wr_take;
  logic        rd_take;
  wr_req_t     wr_seen;
  logic [7:0]  rd_seen;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  initial
  begin
    lfsr       = LFSR_SEED;
    wrrdy_o    = 1'b0;
    rdrdy_o    = 1'b0;
    rdq_o      = '0;
    rdqvalid_o = 1'b0;
    rd_busy    = 1'b0;
    wr_take    = 1'b0;
    rd_take    = 1'b0;
    // fill depends on every address bit
    for (int i = 0; i < 256; i++)
      mem[i] = 8'(i * 37 + 91);
  end

  always @(negedge HCLK)
  begin
    wr_take = wrreq_i & wrrdy_o;
    wr_seen = wr_i;
    rd_take = rdreq_i & rdrdy_o;
    rd_seen = rd_i.addr[7:0];
  end

  ////////////////////
  // scheduler side
  ////////////////////
  always @(posedge HCLK)
  begin
    #2;
    if (!HRESETn)
    begin
      wrrdy_o    = 1'b0;
      rdrdy_o    = 1'b0;
      rdqvalid_o = 1'b0;
      rd_busy    = 1'b0;
      wr_low     = 0;
      rd_low     = 0;
    end
    else
    begin
      rdqvalid_o = 1'b0;
      // line write by byte enable
      if (wr_take)
      begin
        for (int b = 0; b < WB_LINE_BYTES; b++)
          if (wr_seen.be[b])
            mem[8'(wr_seen.addr) + 8'(b)] = wr_seen.data[8*b +: 8];
      end
      if (rd_busy)
      begin
        if (rd_wait == 1)
        begin
          rdq_o      = {mem[rd_ptr + 8'd3], mem[rd_ptr + 8'd2], mem[rd_ptr + 8'd1], mem[rd_ptr]};
          rdqvalid_o = 1'b1;
          rd_busy    = 1'b0;
        end
        else
          rd_wait = rd_wait - 1;
      end
      // one word back after 1 to 8 cycles
      if (rd_take)
      begin
        rd_busy = 1'b1;
        rd_ptr  = rd_seen;
        rd_wait = 1 + rand_bits(3);
      end
      // ready low runs of at most 8 cycles
      if (wr_low != 0)
        wr_low = wr_low - 1;
      else if (rand_bits(2) == 0)
        wr_low = 1 + rand_bits(3);
      if (rd_low != 0)
        rd_low = rd_low - 1;
      else if (rand_bits(2) == 0)
        rd_low = 1 + rand_bits(3);
      wrrdy_o = (wr_low == 0);
      rdrdy_o = (rd_low == 0);
    end
  end

endmodule : sdram_sched_model

`default_nettype wire

//--- testbench/tb_sdram_ahb_port.sv
// testbench for the AHB SDRAM data port with LFSR stimulus, byte reference and checks
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_ahb_port
  import ahb_pkg::*;
  import sdram_port_pkg::*;
();

  localparam logic [31:0] LFSR_SEED     = 32'h2ca1_8f85;
  localparam int          N_OPS         = 400;
  localparam int          OP_MAX_CYC    = 40;
  localparam int          CYC_LIMIT     = 4 * N_OPS * OP_MAX_CYC;
  localparam int          READY_LOW_MAX = 8;
  // timeout swap plus two ready waits
  localparam int          DRAIN_CYC     = WB_TIMEOUT + 4 * (READY_LOW_MAX + 1);

  logic         HCLK;
  logic         HRESETn;
  logic         hsel;
  logic [31:0]  haddr;
  logic [1:0]   htrans;
  logic [2:0]   hsize;
  logic [2:0]   hburst;
  logic         hwrite;
  logic [31:0]  hwdata;
  wire  [31:0]  hrdata;
  wire          hreadyout;
  wire          hresp;
  wire          wrreq;
  wr_req_t      wr;
  wire          wrrdy;
  wire          rdreq;
  rd_req_t      rd;
  wire          rdrdy;
  wire  [31:0]  rdq;
  wire          rdqvalid;

  logic [31:0]  lfsr;
  int           cycle;
  int           errors;
  int           checks;
  logic [7:0]   ref_mem [256];
  // per byte: last AHB write and last two line flushes
  int           last_wr_t [256];
  int           flush_t1  [256];
  int           flush_t2  [256];
  logic         wr_held;
  logic         rd_held;
  wr_req_t      wr_last;
  rd_req_t      rd_last;

  // single slave, HREADY loops back
  sdram_ahb_port dut0 (
    .HCLK (HCLK), .HRESETn (HRESETn), .HSEL_i (hsel), .HADDR_i (haddr), .HTRANS_i (htrans),
    .HSIZE_i (hsize), .HBURST_i (hburst), .HWRITE_i (hwrite), .HWDATA_i (hwdata),
    .HREADY_i (hreadyout), .HRDATA_o (hrdata), .HREADYOUT_o (hreadyout), .HRESP_o (hresp),
    .wrreq_o (wrreq), .wr_o (wr), .wrrdy_i (wrrdy), .rdreq_o (rdreq), .rd_o (rd),
    .rdrdy_i (rdrdy), .rdq_i (rdq), .rdqvalid_i (rdqvalid)
  );

  sdram_sched_model model0 (
    .HCLK (HCLK), .HRESETn (HRESETn), .wrreq_i (wrreq), .wr_i (wr), .wrrdy_o (wrrdy),
    .rdreq_i (rdreq), .rd_i (rd), .rdrdy_o (rdrdy), .rdq_o (rdq), .rdqvalid_o (rdqvalid)
  );

  always #10 HCLK = ~HCLK;

  always @(posedge HCLK)
    cycle = cycle + 1;

  ////////////////////
  // helpers
  ////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic logic [31:0] ref_word(input logic [7:0] a);
    logic [7:0] w;
    w = {a[7:2], 2'b00};
    return {ref_mem[w + 8'd3], ref_mem[w + 8'd2], ref_mem[w + 8'd1], ref_mem[w]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("Mismatch %s: got %08h expected %08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_error(input string msg);
    errors = errors + 1;
    $display("error at %0t: %s", $time, msg);
  endtask

  // returns at the drive point after the edge that had HREADYOUT high
  task automatic wait_ready(output logic [31:0] data);
    logic rdy;
    rdy = 1'b0;
    while (!rdy)
    begin
      @(negedge HCLK);
      rdy  = hreadyout;
      data = hrdata;
      @(posedge HCLK);
      #2;
    end
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++)
    begin
      @(posedge HCLK);
      #2;
    end
  endtask

  // one non-pipelined transfer, address phase then data phase
  task automatic ahb_xfer(input logic wr_en, input logic [7:0] addr, input logic [2:0] size,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    logic [31:0] unused;
    logic [7:0]  a;
    hsel   = 1'b1;
    htrans = HTRANS_NONSEQ;
    haddr  = {24'h0, addr};
    hsize  = size;
    hwrite = wr_en;
    wait_ready(unused);
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
    hwdata = wdata;
    wait_ready(rdata);
    // data sits on the lanes picked by the low address bits
    if (wr_en)
    begin
      for (int k = 0; k < (1 << size); k++)
      begin
        a            = addr + 8'(k);
        ref_mem[a]   = wdata[8*a[1:0] +: 8];
        last_wr_t[a] = cycle;
      end
    end
  endtask

  task automatic note_line_write(input wr_req_t req);
    logic [7:0] a;
    if ((req.addr >> 8) != 0 || req.addr[3:0] != 4'h0)
      report_error("write request address is not a line address inside the window");
    for (int b = 0; b < WB_LINE_BYTES; b++)
    begin
      if (req.be[b])
      begin
        a = 8'(req.addr) + 8'(b);
        // at most one flush of the other line fits between write and flush
        if (last_wr_t[a] <= flush_t2[a])
          report_error($sformatf("write request enables byte %02h %s", a,
                                 "that was not written since its line was flushed"));
        flush_t2[a] = flush_t1[a];
        flush_t1[a] = cycle + 1;
      end
    end
  endtask

  task automatic drain_and_compare();
    idle_cycles(DRAIN_CYC);
    @(negedge HCLK);
    for (int i = 0; i < 256; i++)
      check_value($sformatf("mem[%02h]", i), 32'(model0.mem[i]), 32'(ref_mem[i]));
    @(posedge HCLK);
    #2;
  endtask

  ////////////////////
  // request monitor
  ////////////////////
  always @(negedge HCLK)
  begin
    if (HRESETn)
    begin
      check_value("HRESP_o", 32'(hresp), 32'(HRESP_OKAY));
      if (wr_held && (wrreq !== 1'b1 || wr !== wr_last))
        report_error("write request changed or dropped before it was accepted");
      if (rd_held && (rdreq !== 1'b1 || rd !== rd_last))
        report_error("read request changed or dropped before it was accepted");
      if (wrreq && wrrdy)
        note_line_write(wr);
      if (rdreq && rdrdy && ((rd.addr >> 8) != 0 || rd.addr[1:0] != 2'b00))
        report_error("read request address is not a word inside the window");
      wr_held = wrreq & ~wrrdy;
      rd_held = rdreq & ~rdrdy;
      wr_last = wr;
      rd_last = rd;
    end
  end

  initial
  begin
    wait (cycle >= CYC_LIMIT);
    $display("run stopped after %0d cycles, the tests did not finish", cycle);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////
  // stimulus
  ////////////////////
  initial
  begin
    logic        is_wr;
    logic [2:0]  size;
    logic [7:0]  addr;
    logic [7:0]  last_addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    int          gap_sel;
    HCLK      = 1'b0;
    HRESETn   = 1'b0;
    hsel      = 1'b0;
    haddr     = '0;
    htrans    = HTRANS_IDLE;
    hsize     = HSIZE_WORD;
    hburst    = HBURST_SINGLE;
    hwrite    = 1'b0;
    hwdata    = '0;
    lfsr      = LFSR_SEED;
    cycle     = 0;
    errors    = 0;
    checks    = 0;
    wr_held   = 1'b0;
    rd_held   = 1'b0;
    last_addr = '0;
    for (int i = 0; i < 256; i++)
    begin
      last_wr_t[i] = -1;
      flush_t1[i]  = -1;
      flush_t2[i]  = -1;
    end
    repeat (10) @(posedge HCLK);
    #2;
    HRESETn = 1'b1;
    // reference starts from the model's fill
    for (int i = 0; i < 256; i++)
      ref_mem[i] = model0.mem[i];
    @(negedge HCLK);
    check_value("HREADYOUT_o", 32'(hreadyout), 32'h1);
    check_value("wrreq_o", 32'(wrreq), 32'h0);
    check_value("rdreq_o", 32'(rdreq), 32'h0);
    @(posedge HCLK);
    #2;

    for (int n = 0; n < N_OPS; n++)
    begin
      is_wr = 1'(rand_bits(1));
      size  = 3'(rand_bits(2));
      if (size == 3'd3)
        size = HSIZE_WORD;
      // half the time stay in the last line to merge
      if (rand_bits(1) != 0)
        addr = {last_addr[7:4], 4'(rand_bits(4))};
      else
        addr = 8'(rand_bits(8));
      addr      = addr & ~((8'd1 << size) - 8'd1);
      last_addr = addr;
      wdata     = 32'(rand_bits(32));
      ahb_xfer(is_wr, addr, size, wdata, rdata);
      if (!is_wr)
        check_value("HRDATA_o", rdata, ref_word(addr));
      gap_sel = rand_bits(4);
      if (gap_sel == 0)
        idle_cycles(WB_TIMEOUT + 8);
      else
        idle_cycles(gap_sel % 4);
      if (n % 100 == 99)
        drain_and_compare();
    end

    // whole window read back
    for (int w = 0; w < 64; w++)
    begin
      ahb_xfer(1'b0, 8'(w * 4), HSIZE_WORD, 32'h0, rdata);
      check_value("HRDATA_o", rdata, ref_word(8'(w * 4)));
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule : tb_sdram_ahb_port

`default_nettype wire

//--- sdram_ahb_port.f
hw/ahb_pkg.sv
hw/sdram_port_pkg.sv
hw/ahb_beat_capture.sv
hw/write_combine_buffer.sv
hw/read_sequencer.sv
hw/sdram_ahb_port.sv
testbench/sdram_sched_model.sv
testbench/tb_sdram_ahb_port.sv
